//--- hdl/proc_pkg.sv
// ------------------------------
// one core, word accesses only; manager csrs are 0xfc0 (in) and 0x7c0 (out)
// ------------------------------
`default_nettype none

package proc_pkg;

  // rv32 opcodes used by the decoder
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_imm    = 7'b0010011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_system = 7'b1110011;

  localparam logic [11:0] csr_mngr2proc = 12'hfc0;
  localparam logic [11:0] csr_proc2mngr = 12'h7c0;

  localparam logic [31:0] reset_vector = 32'h0000_0000;
  // addi x0, x0, 0
  localparam logic [31:0] nop_inst     = 32'h0000_0013;

  typedef enum logic [3:0] {
    op_add, op_sub, op_and, op_or, op_slt, op_addi, op_lw,
    op_sw, op_bne, op_jal, op_csrr, op_csrw, op_nop
  } inst_op_e;

  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_slt, alu_cp_op1
  } alu_fn_e;

  typedef enum logic [1:0] {imm_i, imm_s, imm_b, imm_j} imm_type_e;

  typedef enum logic [1:0] {pc_plus4, pc_br_target_x, pc_jal_target_d} pc_sel_e;

  typedef enum logic [1:0] {wb_ex_result, wb_dmem, wb_mngr} wb_sel_e;

  // ------------------------------
  // ctrl to dpath, one field group per stage
  // ------------------------------
  typedef struct packed {
    logic       reg_en_f;
    logic       reg_en_d;
    logic       reg_en_x;
    logic       reg_en_m;
    logic       reg_en_w;
    pc_sel_e    pc_sel;
    logic       op1_is_mngr;
    logic       op1_is_link;
    logic       op2_is_imm;
    imm_type_e  imm_type;
    alu_fn_e    alu_fn;
    wb_sel_e    wb_sel;
    logic       dmem_wen;
    logic       rf_wen_w;
    logic [4:0] rf_waddr_w;
  } ctrl_sigs_t;

  typedef struct packed {
    logic [31:0] inst_d;
    logic        br_cond_ne_x;
  } dpath_status_t;

  // program load port, addr is a word index
  typedef struct packed {
    logic        en;
    logic [31:0] addr;
    logic [31:0] data;
  } mem_load_t;

endpackage

`default_nettype wire

//--- hdl/proc_alu.sv
// ------------------------------
// purely combinational, slt is signed
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module proc_alu (
  input  logic [31:0]       in0,
  input  logic [31:0]       in1,
  input  proc_pkg::alu_fn_e fn,
  output logic [31:0]       result,
  output logic              ops_ne
);

  logic lt_signed;

  assign lt_signed = $signed(in0) < $signed(in1);

  always_comb begin
    case (fn)
      proc_pkg::alu_add:    result = in0 + in1;
      proc_pkg::alu_sub:    result = in0 - in1;
      proc_pkg::alu_and:    result = in0 & in1;
      proc_pkg::alu_or:     result = in0 | in1;
      proc_pkg::alu_slt:    result = {31'd0, lt_signed};
      proc_pkg::alu_cp_op1: result = in0;
      default:              result = 32'd0;
    endcase
  end

  // branch condition for bne
  assign ops_ne = in0 != in1;

endmodule

`default_nettype wire

//--- hdl/proc_regfile.sv
// ------------------------------
// 2r1w, x0 reads zero, write data is forwarded to a same-cycle read
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module proc_regfile (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  rd_addr0,
  output logic [31:0] rd_data0,
  input  logic [4:0]  rd_addr1,
  output logic [31:0] rd_data1,
  input  logic        wr_en,
  input  logic [4:0]  wr_addr,
  input  logic [31:0] wr_data
);

  logic [31:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (wr_en && (wr_addr != 5'd0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // write before read, so W never stalls D
  always_comb begin
    if (rd_addr0 == 5'd0) rd_data0 = 32'd0;
    else if (wr_en && (wr_addr == rd_addr0)) rd_data0 = wr_data;
    else rd_data0 = regs[rd_addr0];

    if (rd_addr1 == 5'd0) rd_data1 = 32'd0;
    else if (wr_en && (wr_addr == rd_addr1)) rd_data1 = wr_data;
    else rd_data1 = regs[rd_addr1];
  end

endmodule

`default_nettype wire

//--- hdl/proc_mem.sv
// ------------------------------
// word memory, one-cycle read latency, never busy
// load port is meant for use during reset only
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module proc_mem #(
  parameter int words = 256
) (
  input  logic                clk,
  input  logic [31:0]         addr,
  input  logic                wen,
  input  logic [31:0]         wdata,
  output logic [31:0]         rdata,
  input  proc_pkg::mem_load_t load
);

  localparam int aw = $clog2(words);

  logic [31:0]   mem [words];
  logic [aw-1:0] idx;

  // byte address in, word index used
  assign idx = addr[aw+1:2];

  always_ff @(posedge clk) begin
    if (load.en) begin
      mem[load.addr[aw-1:0]] <= load.data;
    end else if (wen) begin
      mem[idx] <= wdata;
    end
    rdata <= mem[idx];
  end

endmodule

`default_nettype wire

//--- hdl/proc_dpath.sv
// ------------------------------
// five-stage datapath, no bypass paths; all hazards handled by ctrl
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module proc_dpath (
  input  logic                    clk,
  input  logic                    rst_n,
  input  proc_pkg::ctrl_sigs_t    ctrl,
  output proc_pkg::dpath_status_t status,
  output logic [31:0]             imem_addr,
  input  logic [31:0]             imem_rdata,
  output logic [31:0]             dmem_addr,
  output logic [31:0]             dmem_wdata,
  input  logic [31:0]             dmem_rdata,
  input  logic [31:0]             mngr2proc_data,
  output logic [31:0]             proc2mngr_data
);

  // ------------------------------
  // F stage
  // ------------------------------
  logic [31:0] pc_f;
  logic [31:0] pc_plus4_f;
  logic [31:0] pc_target_f;
  logic [31:0] pc_next_f;
  logic [31:0] jal_target_d;
  logic [31:0] br_target_x;
  logic        fetch_live;
  logic        squash_f;

  assign pc_plus4_f = pc_f + 32'd4;

  always_comb begin
    case (ctrl.pc_sel)
      proc_pkg::pc_br_target_x:  pc_target_f = br_target_x;
      proc_pkg::pc_jal_target_d: pc_target_f = jal_target_d;
      default:                   pc_target_f = pc_plus4_f;
    endcase
  end

  // a held F re-reads its own pc so imem_rdata stays matched to pc_f
  assign pc_next_f = ctrl.reg_en_f ? pc_target_f : pc_f;
  assign imem_addr = pc_next_f;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_f       <= proc_pkg::reset_vector - 32'd4;
      fetch_live <= 1'b0;
    end else begin
      pc_f       <= pc_next_f;
      fetch_live <= fetch_live | ctrl.reg_en_f;
    end
  end

  // any redirect kills the word in F; first slot after reset is empty
  assign squash_f = (ctrl.pc_sel != proc_pkg::pc_plus4) || !fetch_live;

  // ------------------------------
  // D stage
  // ------------------------------
  logic [31:0] inst_d;
  logic [31:0] pc_d;
  logic [31:0] imm_d;
  logic [31:0] rf_rdata0_d;
  logic [31:0] rf_rdata1_d;
  logic [31:0] op1_d;
  logic [31:0] op2_d;
  logic [31:0] rf_wdata_w;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      inst_d <= proc_pkg::nop_inst;
    end else if (ctrl.reg_en_d) begin
      inst_d <= squash_f ? proc_pkg::nop_inst : imem_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.reg_en_d) begin
      pc_d <= pc_f;
    end
  end

  always_comb begin
    case (ctrl.imm_type)
      proc_pkg::imm_s: imm_d = {{20{inst_d[31]}}, inst_d[31:25], inst_d[11:7]};
      proc_pkg::imm_b: imm_d = {{19{inst_d[31]}}, inst_d[31], inst_d[7],
                                inst_d[30:25], inst_d[11:8], 1'b0};
      proc_pkg::imm_j: imm_d = {{11{inst_d[31]}}, inst_d[31], inst_d[19:12],
                                inst_d[20], inst_d[30:21], 1'b0};
      default:         imm_d = {{20{inst_d[31]}}, inst_d[31:20]};
    endcase
  end

  proc_regfile u_rf (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_addr0 (inst_d[19:15]),
    .rd_data0 (rf_rdata0_d),
    .rd_addr1 (inst_d[24:20]),
    .rd_data1 (rf_rdata1_d),
    .wr_en    (ctrl.rf_wen_w),
    .wr_addr  (ctrl.rf_waddr_w),
    .wr_data  (rf_wdata_w)
  );

  // csrr takes the stream word, jal carries its link value
  always_comb begin
    if (ctrl.op1_is_mngr) op1_d = mngr2proc_data;
    else if (ctrl.op1_is_link) op1_d = pc_d + 32'd4;
    else op1_d = rf_rdata0_d;
  end

  assign op2_d        = ctrl.op2_is_imm ? imm_d : rf_rdata1_d;
  assign jal_target_d = pc_d + imm_d;

  // ------------------------------
  // X stage
  // ------------------------------
  logic [31:0] op1_x;
  logic [31:0] op2_x;
  logic [31:0] st_data_x;
  logic [31:0] alu_result_x;
  logic        br_ne_x;
  logic [31:0] ex_result_m;

  always_ff @(posedge clk) begin
    if (ctrl.reg_en_x) begin
      op1_x       <= op1_d;
      op2_x       <= op2_d;
      st_data_x   <= rf_rdata1_d;
      br_target_x <= jal_target_d;
    end
  end

  proc_alu u_alu (
    .in0    (op1_x),
    .in1    (op2_x),
    .fn     (ctrl.alu_fn),
    .result (alu_result_x),
    .ops_ne (br_ne_x)
  );

  assign status = '{inst_d: inst_d, br_cond_ne_x: br_ne_x};

  // while M is held, keep reading the address of the load sitting in M
  assign dmem_addr  = ctrl.reg_en_m ? alu_result_x : ex_result_m;
  assign dmem_wdata = st_data_x;

  // ------------------------------
  // M and W stages
  // ------------------------------
  logic [31:0] wb_result_m;
  logic [31:0] wb_result_w;

  always_ff @(posedge clk) begin
    if (ctrl.reg_en_m) begin
      ex_result_m <= alu_result_x;
    end
  end

  assign wb_result_m = (ctrl.wb_sel == proc_pkg::wb_dmem) ? dmem_rdata : ex_result_m;

  always_ff @(posedge clk) begin
    if (ctrl.reg_en_w) begin
      wb_result_w <= wb_result_m;
    end
  end

  assign rf_wdata_w     = wb_result_w;
  assign proc2mngr_data = wb_result_w;

endmodule

`default_nettype wire

//--- hdl/proc_ctrl.sv
// ------------------------------
// stall-only hazard handling; bne resolves in X, jal in D
// proc2mngr back-pressure freezes every stage
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module proc_ctrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  proc_pkg::dpath_status_t status,
  output proc_pkg::ctrl_sigs_t    ctrl,
  input  logic                    mngr2proc_valid,
  output logic                    mngr2proc_ready,
  output logic                    proc2mngr_valid,
  input  logic                    proc2mngr_ready
);

  // control fields that travel with each instruction
  typedef struct packed {
    logic               val;
    proc_pkg::inst_op_e op;
    proc_pkg::alu_fn_e  alu_fn;
    proc_pkg::wb_sel_e  wb_sel;
    logic               rf_wen;
    logic [4:0]         rd;
  } stage_t;

  localparam stage_t nop_stage = '{
    val: 1'b0, op: proc_pkg::op_nop, alu_fn: proc_pkg::alu_add,
    wb_sel: proc_pkg::wb_ex_result, rf_wen: 1'b0, rd: 5'd0
  };

  function automatic logic raw_hit(input stage_t s, input logic [4:0] rs);
    return s.val && s.rf_wen && (s.rd == rs);
  endfunction

  // ------------------------------
  // decode
  // ------------------------------
  logic [31:0]         inst;
  logic [4:0]          rs1;
  logic [4:0]          rs2;
  logic [4:0]          rd;
  proc_pkg::inst_op_e  op_d;
  logic                rs1_en;
  logic                rs2_en;
  logic                writes_rd;
  logic                op1_is_mngr;
  logic                op1_is_link;
  logic                op2_is_imm;
  proc_pkg::imm_type_e imm_type;
  proc_pkg::alu_fn_e   alu_fn;
  proc_pkg::wb_sel_e   wb_sel;

  assign inst = status.inst_d;
  assign rs1  = inst[19:15];
  assign rs2  = inst[24:20];
  assign rd   = inst[11:7];

  always_comb begin
    op_d = proc_pkg::op_nop;
    case (inst[6:0])
      proc_pkg::opc_op: begin
        case ({inst[31:25], inst[14:12]})
          10'b0000000_000: op_d = proc_pkg::op_add;
          10'b0100000_000: op_d = proc_pkg::op_sub;
          10'b0000000_111: op_d = proc_pkg::op_and;
          10'b0000000_110: op_d = proc_pkg::op_or;
          10'b0000000_010: op_d = proc_pkg::op_slt;
          default:         op_d = proc_pkg::op_nop;
        endcase
      end
      proc_pkg::opc_imm:    if (inst[14:12] == 3'b000) op_d = proc_pkg::op_addi;
      proc_pkg::opc_load:   if (inst[14:12] == 3'b010) op_d = proc_pkg::op_lw;
      proc_pkg::opc_store:  if (inst[14:12] == 3'b010) op_d = proc_pkg::op_sw;
      proc_pkg::opc_branch: if (inst[14:12] == 3'b001) op_d = proc_pkg::op_bne;
      proc_pkg::opc_jal:    op_d = proc_pkg::op_jal;
      proc_pkg::opc_system: begin
        if (inst[14:12] == 3'b010 && inst[31:20] == proc_pkg::csr_mngr2proc) begin
          op_d = proc_pkg::op_csrr;
        end else if (inst[14:12] == 3'b001 && inst[31:20] == proc_pkg::csr_proc2mngr) begin
          op_d = proc_pkg::op_csrw;
        end
      end
      default: op_d = proc_pkg::op_nop;
    endcase
  end

  always_comb begin
    rs1_en      = 1'b0;
    rs2_en      = 1'b0;
    writes_rd   = 1'b0;
    op1_is_mngr = 1'b0;
    op1_is_link = 1'b0;
    op2_is_imm  = 1'b0;
    imm_type    = proc_pkg::imm_i;
    alu_fn      = proc_pkg::alu_add;
    wb_sel      = proc_pkg::wb_ex_result;
    case (op_d)
      proc_pkg::op_add, proc_pkg::op_sub, proc_pkg::op_and,
      proc_pkg::op_or, proc_pkg::op_slt: begin
        rs1_en    = 1'b1;
        rs2_en    = 1'b1;
        writes_rd = 1'b1;
        case (op_d)
          proc_pkg::op_sub: alu_fn = proc_pkg::alu_sub;
          proc_pkg::op_and: alu_fn = proc_pkg::alu_and;
          proc_pkg::op_or:  alu_fn = proc_pkg::alu_or;
          proc_pkg::op_slt: alu_fn = proc_pkg::alu_slt;
          default:          alu_fn = proc_pkg::alu_add;
        endcase
      end
      proc_pkg::op_addi, proc_pkg::op_lw: begin
        rs1_en     = 1'b1;
        writes_rd  = 1'b1;
        op2_is_imm = 1'b1;
        if (op_d == proc_pkg::op_lw) wb_sel = proc_pkg::wb_dmem;
      end
      proc_pkg::op_sw: begin
        rs1_en     = 1'b1;
        rs2_en     = 1'b1;
        op2_is_imm = 1'b1;
        imm_type   = proc_pkg::imm_s;
      end
      proc_pkg::op_bne: begin
        rs1_en   = 1'b1;
        rs2_en   = 1'b1;
        imm_type = proc_pkg::imm_b;
        alu_fn   = proc_pkg::alu_sub;
      end
      proc_pkg::op_jal: begin
        writes_rd   = 1'b1;
        op1_is_link = 1'b1;
        imm_type    = proc_pkg::imm_j;
        alu_fn      = proc_pkg::alu_cp_op1;
      end
      proc_pkg::op_csrr: begin
        writes_rd   = 1'b1;
        op1_is_mngr = 1'b1;
        alu_fn      = proc_pkg::alu_cp_op1;
        wb_sel      = proc_pkg::wb_mngr;
      end
      proc_pkg::op_csrw: begin
        rs1_en = 1'b1;
        alu_fn = proc_pkg::alu_cp_op1;
      end
      default: ;
    endcase
  end

  // ------------------------------
  // hazards and pipeline
  // ------------------------------
  stage_t ctl_d;
  stage_t ctl_x;
  stage_t ctl_m;
  stage_t ctl_w;
  logic   freeze;
  logic   stall_sb;
  logic   stall_mngr;
  logic   stall_d;
  logic   br_taken_x;
  logic   advance_fd;

  // x0 never counts as a destination
  assign ctl_d = '{val: op_d != proc_pkg::op_nop, op: op_d, alu_fn: alu_fn, wb_sel: wb_sel,
                   rf_wen: writes_rd && (rd != 5'd0), rd: rd};

  assign proc2mngr_valid = ctl_w.val && (ctl_w.op == proc_pkg::op_csrw);
  assign freeze          = proc2mngr_valid && !proc2mngr_ready;

  // producers in W are covered by the regfile write-through
  assign stall_sb   = (rs1_en && (raw_hit(ctl_x, rs1) || raw_hit(ctl_m, rs1)))
                    || (rs2_en && (raw_hit(ctl_x, rs2) || raw_hit(ctl_m, rs2)));
  assign stall_mngr = (op_d == proc_pkg::op_csrr) && !mngr2proc_valid;
  assign stall_d    = stall_sb || stall_mngr || freeze;

  assign br_taken_x = ctl_x.val && (ctl_x.op == proc_pkg::op_bne) && status.br_cond_ne_x;
  // a taken branch overrides a stall in D, the stalled word dies anyway
  assign advance_fd = !freeze && (!stall_d || br_taken_x);

  assign mngr2proc_ready = (op_d == proc_pkg::op_csrr) && !stall_sb && !freeze && !br_taken_x;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ctl_x <= nop_stage;
      ctl_m <= nop_stage;
      ctl_w <= nop_stage;
    end else if (!freeze) begin
      ctl_x <= (stall_d || br_taken_x) ? nop_stage : ctl_d;
      ctl_m <= ctl_x;
      ctl_w <= ctl_m;
    end
  end

  always_comb begin
    ctrl.reg_en_f    = advance_fd;
    ctrl.reg_en_d    = advance_fd;
    ctrl.reg_en_x    = !freeze;
    ctrl.reg_en_m    = !freeze;
    ctrl.reg_en_w    = !freeze;
    if (br_taken_x) ctrl.pc_sel = proc_pkg::pc_br_target_x;
    else if (op_d == proc_pkg::op_jal) ctrl.pc_sel = proc_pkg::pc_jal_target_d;
    else ctrl.pc_sel = proc_pkg::pc_plus4;
    ctrl.op1_is_mngr = op1_is_mngr;
    ctrl.op1_is_link = op1_is_link;
    ctrl.op2_is_imm  = op2_is_imm;
    ctrl.imm_type    = imm_type;
    ctrl.alu_fn      = ctl_x.alu_fn;
    ctrl.wb_sel      = ctl_m.wb_sel;
    ctrl.dmem_wen    = ctl_x.val && (ctl_x.op == proc_pkg::op_sw) && !freeze;
    ctrl.rf_wen_w    = ctl_w.val && ctl_w.rf_wen;
    ctrl.rf_waddr_w  = ctl_w.rd;
  end

endmodule

`default_nettype wire

//--- hdl/proc_top.sv
// ------------------------------
// imem is loaded through imem_load while rst_n is low
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module proc_top #(
  parameter int imem_words = 256,
  parameter int dmem_words = 256
) (
  input  logic                clk,
  input  logic                rst_n,
  input  proc_pkg::mem_load_t imem_load,
  input  logic [31:0]         mngr2proc_data,
  input  logic                mngr2proc_valid,
  output logic                mngr2proc_ready,
  output logic [31:0]         proc2mngr_data,
  output logic                proc2mngr_valid,
  input  logic                proc2mngr_ready
);

  proc_pkg::ctrl_sigs_t    ctrl_sigs;
  proc_pkg::dpath_status_t status;
  logic [31:0]             imem_addr;
  logic [31:0]             imem_rdata;
  logic [31:0]             dmem_addr;
  logic [31:0]             dmem_wdata;
  logic [31:0]             dmem_rdata;

  proc_ctrl u_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .status          (status),
    .ctrl            (ctrl_sigs),
    .mngr2proc_valid (mngr2proc_valid),
    .mngr2proc_ready (mngr2proc_ready),
    .proc2mngr_valid (proc2mngr_valid),
    .proc2mngr_ready (proc2mngr_ready)
  );

  proc_dpath u_dpath (
    .clk            (clk),
    .rst_n          (rst_n),
    .ctrl           (ctrl_sigs),
    .status         (status),
    .imem_addr      (imem_addr),
    .imem_rdata     (imem_rdata),
    .dmem_addr      (dmem_addr),
    .dmem_wdata     (dmem_wdata),
    .dmem_rdata     (dmem_rdata),
    .mngr2proc_data (mngr2proc_data),
    .proc2mngr_data (proc2mngr_data)
  );

  // instruction memory, read-only once the program is loaded
  proc_mem #(.words(imem_words)) u_imem (
    .clk   (clk),
    .addr  (imem_addr),
    .wen   (1'b0),
    .wdata (32'd0),
    .rdata (imem_rdata),
    .load  (imem_load)
  );

  proc_mem #(.words(dmem_words)) u_dmem (
    .clk   (clk),
    .addr  (dmem_addr),
    .wen   (ctrl_sigs.dmem_wen),
    .wdata (dmem_wdata),
    .rdata (dmem_rdata),
    .load  ('0)
  );

endmodule

`default_nettype wire

//--- verification/proc_top_asserts.sv
// ------------------------------
// bound into proc_ctrl, checks handshake hold and reset state
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module proc_top_asserts (
  input logic                 clk,
  input logic                 rst_n,
  input proc_pkg::ctrl_sigs_t ctrl,
  input logic                 mngr2proc_ready,
  input logic                 proc2mngr_valid,
  input logic                 proc2mngr_ready
);

  int fail_count = 0;

  hold_valid: assert property (@(posedge clk) disable iff (!rst_n)
    proc2mngr_valid && !proc2mngr_ready |=> proc2mngr_valid)
    else begin
      $error("proc2mngr_valid dropped before ready");
      fail_count++;
    end

  reset_quiet: assert property (@(posedge clk)
    $rose(rst_n) |-> !ctrl.rf_wen_w && !ctrl.dmem_wen && !proc2mngr_valid && !mngr2proc_ready)
    else begin
      $error("control active right after reset release");
      fail_count++;
    end

  no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl.rf_wen_w |-> ctrl.rf_waddr_w != 5'd0)
    else begin
      $error("register file write to x0");
      fail_count++;
    end

endmodule

bind proc_ctrl proc_top_asserts u_asserts (
  .clk             (clk),
  .rst_n           (rst_n),
  .ctrl            (ctrl),
  .mngr2proc_ready (mngr2proc_ready),
  .proc2mngr_valid (proc2mngr_valid),
  .proc2mngr_ready (proc2mngr_ready)
);

`default_nettype wire

//--- verification/proc_top_tb.sv
// ------------------------------
// program image loops forever; one table row feeds two words a and b
// reset spans the program load, then two idle cycles
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module proc_top_tb;

  typedef struct packed {
    logic [31:0] a;
    logic [31:0] b;
    logic        taken;
  } row_t;

  localparam int num_rows    = 8;
  localparam int prog_len    = 27;
  localparam int jal_word    = 22;
  localparam int row_timeout = 500;

  logic                clk;
  logic                rst_n;
  proc_pkg::mem_load_t imem_load;
  logic [31:0]         mngr2proc_data;
  logic                mngr2proc_valid;
  logic                mngr2proc_ready;
  logic [31:0]         proc2mngr_data;
  logic                proc2mngr_valid;
  logic                proc2mngr_ready;

  row_t        rows [num_rows];
  logic [31:0] prog [prog_len];
  logic [31:0] in_q [$];
  logic [31:0] exp_q [$];
  int          errors;
  int          checks;
  int          rows_done;
  logic        timed_out;

  proc_top #(.imem_words(256), .dmem_words(256)) u_dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .imem_load       (imem_load),
    .mngr2proc_data  (mngr2proc_data),
    .mngr2proc_valid (mngr2proc_valid),
    .mngr2proc_ready (mngr2proc_ready),
    .proc2mngr_data  (proc2mngr_data),
    .proc2mngr_valid (proc2mngr_valid),
    .proc2mngr_ready (proc2mngr_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ------------------------------
  // rv32 instruction encoders
  // ------------------------------
  function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_format(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_format(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_format(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // x1 = a, x2 = b, x3..x7 scratch; csrr is csrrs, csrw is csrrw
  task automatic build_program();
    prog[0]  = i_format(12'hfc0, 5'd0, 3'b010, 5'd1, 7'h73);
    prog[1]  = i_format(12'hfc0, 5'd0, 3'b010, 5'd2, 7'h73);
    prog[2]  = r_format(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
    prog[3]  = i_format(12'h7c0, 5'd3, 3'b001, 5'd0, 7'h73);
    prog[4]  = r_format(7'h20, 3'b000, 5'd3, 5'd1, 5'd2);
    prog[5]  = prog[3];
    prog[6]  = r_format(7'h00, 3'b111, 5'd3, 5'd1, 5'd2);
    prog[7]  = prog[3];
    prog[8]  = r_format(7'h00, 3'b110, 5'd3, 5'd1, 5'd2);
    prog[9]  = prog[3];
    prog[10] = r_format(7'h00, 3'b010, 5'd3, 5'd1, 5'd2);
    prog[11] = prog[3];
    prog[12] = i_format(12'd7, 5'd1, 3'b000, 5'd3, 7'h13);
    prog[13] = prog[3];
    prog[14] = s_format(12'd16, 5'd1, 5'd0);
    prog[15] = i_format(12'd16, 5'd0, 3'b010, 5'd4, 7'h03);
    prog[16] = i_format(12'h7c0, 5'd4, 3'b001, 5'd0, 7'h73);
    // bne skips words 18 and 19
    prog[17] = b_format(13'd12, 5'd2, 5'd1);
    prog[18] = i_format(12'd1, 5'd0, 3'b000, 5'd5, 7'h13);
    prog[19] = i_format(12'h7c0, 5'd5, 3'b001, 5'd0, 7'h73);
    prog[20] = i_format(12'd2, 5'd0, 3'b000, 5'd5, 7'h13);
    prog[21] = prog[19];
    // jal skips words 23 and 24
    prog[22] = j_format(21'd12, 5'd6);
    prog[23] = i_format(12'd3, 5'd0, 3'b000, 5'd7, 7'h13);
    prog[24] = i_format(12'h7c0, 5'd7, 3'b001, 5'd0, 7'h73);
    prog[25] = i_format(12'h7c0, 5'd6, 3'b001, 5'd0, 7'h73);
    prog[26] = j_format(-21'sd104, 5'd0);
  endtask

  task automatic load_program();
    for (int i = 0; i < prog_len; i++) begin
      @(negedge clk);
      imem_load = '{en: 1'b1, addr: i, data: prog[i]};
    end
    @(negedge clk);
    imem_load = '0;
  endtask

  // expected output words of one pass through the program
  task automatic expect_row(input row_t r);
    in_q.push_back(r.a);
    in_q.push_back(r.b);
    exp_q.push_back(r.a + r.b);
    exp_q.push_back(r.a - r.b);
    exp_q.push_back(r.a & r.b);
    exp_q.push_back(r.a | r.b);
    exp_q.push_back(($signed(r.a) < $signed(r.b)) ? 32'd1 : 32'd0);
    exp_q.push_back(r.a + 32'd7);
    exp_q.push_back(r.a);
    if (!r.taken) exp_q.push_back(32'd1);
    exp_q.push_back(32'd2);
    exp_q.push_back(proc_pkg::reset_vector + 32'(4 * (jal_word + 1)));
  endtask

  task automatic run_row(input int idx);
    int          cycles;
    int          got;
    int          errors_before;
    logic        offered;
    logic        held;
    logic [31:0] held_data;
    cycles        = 0;
    got           = 0;
    errors_before = errors;
    offered       = 1'b0;
    held          = 1'b0;
    held_data     = 32'd0;
    expect_row(rows[idx]);
    while (exp_q.size() > 0 && cycles < row_timeout) begin
      @(negedge clk);
      cycles++;
      if (!offered && in_q.size() > 0 && ($urandom % 4) != 0) offered = 1'b1;
      mngr2proc_valid = offered;
      mngr2proc_data  = offered ? in_q[0] : 32'd0;
      proc2mngr_ready = ($urandom % 3) != 0;
      // inputs hold until the next falling edge, so this predicts the rising edge
      #1;
      // a word refused on the last edge must still be there
      if (held) begin
        assert (proc2mngr_data == held_data) else begin
          $display("ERROR: proc2mngr_data held %h got %h", held_data, proc2mngr_data);
          errors++;
        end
      end
      if (mngr2proc_valid && mngr2proc_ready) begin
        void'(in_q.pop_front());
        offered = 1'b0;
      end
      if (proc2mngr_valid && proc2mngr_ready) begin
        checks++;
        got++;
        assert (proc2mngr_data == exp_q[0]) else begin
          $display("ERROR: proc2mngr_data expected %h got %h", exp_q[0], proc2mngr_data);
          errors++;
        end
        void'(exp_q.pop_front());
      end
      held      = proc2mngr_valid && !proc2mngr_ready;
      held_data = proc2mngr_data;
    end
    if (exp_q.size() > 0) begin
      $display("timeout: row %0d still waits for %0d output words", idx, exp_q.size());
      errors++;
      timed_out = 1'b1;
    end
    $display("row %0d a=%h b=%h: %0d words, %0d errors", idx, rows[idx].a, rows[idx].b,
             got, errors - errors_before);
  endtask

  // no extra output word and no unread input once the table is done
  task automatic check_idle();
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      mngr2proc_valid = 1'b0;
      proc2mngr_ready = 1'b1;
      #1;
      assert (!proc2mngr_valid) else begin
        $display("unexpected output word %h after the last row", proc2mngr_data);
        errors++;
      end
    end
    assert (in_q.size() == 0) else begin
      $display("%0d input words were never read", in_q.size());
      errors++;
    end
  endtask

  initial begin
    rst_n           = 1'b0;
    imem_load       = '0;
    mngr2proc_data  = 32'd0;
    mngr2proc_valid = 1'b0;
    proc2mngr_ready = 1'b0;
    errors          = 0;
    checks          = 0;
    rows_done       = 0;
    timed_out       = 1'b0;
    void'($urandom(15997));

    // a, b, branch taken
    rows[0] = '{a: 32'd5,          b: 32'd3,          taken: 1'b1};
    rows[1] = '{a: 32'd7,          b: 32'd7,          taken: 1'b0};
    rows[2] = '{a: 32'hffff_fff0,  b: 32'h0000_0010,  taken: 1'b1};
    rows[3] = '{a: 32'h0000_0010,  b: 32'hffff_fff0,  taken: 1'b1};
    rows[4] = '{a: 32'd0,          b: 32'd0,          taken: 1'b0};
    rows[5] = '{a: 32'h8000_0000,  b: 32'h7fff_ffff,  taken: 1'b1};
    rows[6] = '{a: 32'h1234_5678,  b: 32'h1234_5678,  taken: 1'b0};
    rows[7] = '{a: 32'hdead_beef,  b: 32'h0bad_f00d,  taken: 1'b1};

    build_program();
    load_program();
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < num_rows && !timed_out; i++) begin
      run_row(i);
      rows_done++;
    end
    if (!timed_out) check_idle();

    // failures of the bound assertions
    errors += u_dut.u_ctrl.u_asserts.fail_count;

    $display("rows %0d, checks %0d, errors %0d", rows_done, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- proc_top.f
hdl/proc_pkg.sv
hdl/proc_alu.sv
hdl/proc_regfile.sv
hdl/proc_mem.sv
hdl/proc_dpath.sv
hdl/proc_ctrl.sv
hdl/proc_top.sv
verification/proc_top_asserts.sv
verification/proc_top_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f proc_top.f --top-module proc_top_tb

status=0
out=$(./obj_dir/Vproc_top_tb) || status=$?
echo "$out"
[ "$status" -eq 0 ]
echo "$out" | grep -qx "test passed"
